//--- rsv_pkg.sv
package rsv_pkg;

    // Queue geometry.
    localparam int RSV_ENTRIES = 16;
    localparam int RSV_IDX_W   = 4;

    // ROB id with the wrap bit on top.
    localparam int ROB_ID_W    = 8;

    localparam int DSP_LANES   = 2;
    localparam int ISSUE_PORTS = 2;

    // Issue port numbers.
    localparam int PORT_INT    = 0;
    localparam int PORT_MEM    = 1;

    typedef enum logic [2:0] {
        ALU    = 3'd0,
        CSR    = 3'd1,
        BJP    = 3'd2,
        MULDIV = 3'd3,
        AGU    = 3'd4,
        AMO    = 3'd5
    } exec_unit_e;

    typedef logic [RSV_ENTRIES-1:0] rsv_vec_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_ID_W-1:0]  rob_id;
        exec_unit_e           unit;
    } dsp_req_t;

    typedef struct packed {
        logic                 valid;
        logic [RSV_IDX_W-1:0] entry;
    } free_offer_t;

    typedef struct packed {
        logic                 valid;
        logic [RSV_IDX_W-1:0] entry;
        logic [ROB_ID_W-1:0]  rob_id;
        exec_unit_e           unit;
    } entry_wr_t;

    typedef struct packed {
        logic                 valid;
        logic [ROB_ID_W-1:0]  rob_id;
        exec_unit_e           unit;
    } entry_t;

    typedef struct packed {
        logic                 trap;
        logic                 mis;
        logic [ROB_ID_W-1:0]  mis_rob_id;
    } flush_t;

    typedef struct packed {
        logic                 valid;
        logic [RSV_IDX_W-1:0] entry;
        logic [ROB_ID_W-1:0]  rob_id;
    } issue_t;

    // True when id_a is older than id_b.
    function automatic logic rob_older(input logic [ROB_ID_W-1:0] id_a,
                                       input logic [ROB_ID_W-1:0] id_b);
        if (id_a[ROB_ID_W-1] != id_b[ROB_ID_W-1]) begin
            return id_a[ROB_ID_W-2:0] >= id_b[ROB_ID_W-2:0];
        end
        return id_a[ROB_ID_W-2:0] < id_b[ROB_ID_W-2:0];
    endfunction

endpackage

//--- rsv_alloc.sv
`timescale 1ns/10ps

module rsv_alloc (
    input  rsv_pkg::dsp_req_t    i_dsp [rsv_pkg::DSP_LANES],
    input  rsv_pkg::rsv_vec_t    i_valid_vec,
    output rsv_pkg::free_offer_t o_free [rsv_pkg::DSP_LANES],
    output rsv_pkg::entry_wr_t   o_wr [rsv_pkg::DSP_LANES]
);

    rsv_pkg::rsv_vec_t free_vec;
    rsv_pkg::rsv_vec_t free_rest;

    // Lowest set bit of the free vector.
    function automatic rsv_pkg::free_offer_t find_lowest(input rsv_pkg::rsv_vec_t vec);
        rsv_pkg::free_offer_t res;
        res = '0;
        for (int i = rsv_pkg::RSV_ENTRIES - 1; i >= 0; i--) begin
            if (vec[i]) begin
                res.valid = 1'b1;
                res.entry = rsv_pkg::RSV_IDX_W'(i);
            end
        end
        return res;
    endfunction

    assign free_vec = ~i_valid_vec;

    // Each finder sees the free vector minus the earlier offers.
    always_comb begin
        free_rest = free_vec;
        for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
            o_free[k] = find_lowest(free_rest);
            free_rest[o_free[k].entry] = 1'b0;
        end
    end

    // Lane k always lands in offer k.
    always_comb begin
        for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
            o_wr[k].valid  = i_dsp[k].valid & o_free[k].valid;
            o_wr[k].entry  = o_free[k].entry;
            o_wr[k].rob_id = i_dsp[k].rob_id;
            o_wr[k].unit   = i_dsp[k].unit;
        end
    end

endmodule

//--- rsv_entry_table.sv
`timescale 1ns/10ps

module rsv_entry_table (
    input  logic               clk,
    input  logic               i_rst,
    input  rsv_pkg::entry_wr_t i_wr [rsv_pkg::DSP_LANES],
    input  rsv_pkg::rsv_vec_t  i_release,
    input  rsv_pkg::flush_t    i_flush,
    output rsv_pkg::entry_t    o_entries [rsv_pkg::RSV_ENTRIES],
    output rsv_pkg::rsv_vec_t  o_valid_vec
);

    rsv_pkg::rsv_vec_t            valid_q;
    rsv_pkg::rsv_vec_t            valid_d;
    rsv_pkg::rsv_vec_t            mis_kill;
    logic [rsv_pkg::ROB_ID_W-1:0] rob_id_q [rsv_pkg::RSV_ENTRIES];
    rsv_pkg::exec_unit_e          unit_q [rsv_pkg::RSV_ENTRIES];
    logic                         wr_block;

    // No dispatch lands during any flush.
    assign wr_block = i_flush.trap | i_flush.mis;

    // Entries younger than the mispredicted ROB id.
    always_comb begin
        for (int j = 0; j < rsv_pkg::RSV_ENTRIES; j++) begin
            mis_kill[j] = i_flush.mis & rsv_pkg::rob_older(i_flush.mis_rob_id, rob_id_q[j]);
        end
    end

    always_comb begin
        valid_d = valid_q & ~i_release & ~mis_kill;
        if (!wr_block) begin
            for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
                if (i_wr[k].valid) begin
                    valid_d[i_wr[k].entry] = 1'b1;
                end
            end
        end
        // Trap wins over everything.
        if (i_flush.trap) begin
            valid_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
            if (i_wr[k].valid && !wr_block) begin
                rob_id_q[i_wr[k].entry] <= i_wr[k].rob_id;
                unit_q[i_wr[k].entry]   <= i_wr[k].unit;
            end
        end
    end

    assign o_valid_vec = valid_q;

    always_comb begin
        for (int j = 0; j < rsv_pkg::RSV_ENTRIES; j++) begin
            o_entries[j].valid  = valid_q[j];
            o_entries[j].rob_id = rob_id_q[j];
            o_entries[j].unit   = unit_q[j];
        end
    end

endmodule

//--- rsv_issue_select.sv
`timescale 1ns/10ps

module rsv_issue_select (
    input  rsv_pkg::entry_t                 i_entries [rsv_pkg::RSV_ENTRIES],
    input  rsv_pkg::rsv_vec_t               i_src1_rdy,
    input  rsv_pkg::rsv_vec_t               i_src2_rdy,
    input  logic [rsv_pkg::ISSUE_PORTS-1:0] i_issue_stall,
    output rsv_pkg::issue_t                 o_issue [rsv_pkg::ISSUE_PORTS],
    output rsv_pkg::rsv_vec_t               o_release
);

    rsv_pkg::rsv_vec_t ready_vec;
    rsv_pkg::rsv_vec_t cand [rsv_pkg::ISSUE_PORTS];

    // Unit classes routed to each port.
    function automatic logic port_serves(input int port, input rsv_pkg::exec_unit_e unit);
        logic serves;
        serves = 1'b0;
        case (port)
            rsv_pkg::PORT_INT: begin
                serves = unit inside {rsv_pkg::ALU, rsv_pkg::CSR, rsv_pkg::BJP, rsv_pkg::MULDIV};
            end
            rsv_pkg::PORT_MEM: begin
                serves = unit inside {rsv_pkg::AGU, rsv_pkg::AMO};
            end
            default: begin
                serves = 1'b0;
            end
        endcase
        return serves;
    endfunction

    assign ready_vec = i_src1_rdy & i_src2_rdy;

    always_comb begin
        for (int p = 0; p < rsv_pkg::ISSUE_PORTS; p++) begin
            for (int j = 0; j < rsv_pkg::RSV_ENTRIES; j++) begin
                cand[p][j] = i_entries[j].valid & ready_vec[j]
                           & port_serves(p, i_entries[j].unit);
            end
        end
    end

    // Oldest candidate per port. Strict compare keeps the lower index on a tie.
    always_comb begin
        for (int p = 0; p < rsv_pkg::ISSUE_PORTS; p++) begin
            o_issue[p] = '0;
            for (int j = 0; j < rsv_pkg::RSV_ENTRIES; j++) begin
                if (cand[p][j] && (!o_issue[p].valid ||
                    rsv_pkg::rob_older(i_entries[j].rob_id, o_issue[p].rob_id))) begin
                    o_issue[p].valid  = 1'b1;
                    o_issue[p].entry  = rsv_pkg::RSV_IDX_W'(j);
                    o_issue[p].rob_id = i_entries[j].rob_id;
                end
            end
        end
    end

    // A stalled port keeps its entry.
    always_comb begin
        o_release = '0;
        for (int p = 0; p < rsv_pkg::ISSUE_PORTS; p++) begin
            if (o_issue[p].valid && !i_issue_stall[p]) begin
                o_release[o_issue[p].entry] = 1'b1;
            end
        end
    end

endmodule

//--- rsv_ctrl.sv
`timescale 1ns/10ps

module rsv_ctrl (
    input  logic                            clk,
    input  logic                            i_rst,
    input  rsv_pkg::dsp_req_t               i_dsp [rsv_pkg::DSP_LANES],
    input  rsv_pkg::flush_t                 i_flush,
    input  rsv_pkg::rsv_vec_t               i_src1_rdy,
    input  rsv_pkg::rsv_vec_t               i_src2_rdy,
    input  logic [rsv_pkg::ISSUE_PORTS-1:0] i_issue_stall,
    output rsv_pkg::free_offer_t            o_free [rsv_pkg::DSP_LANES],
    output rsv_pkg::issue_t                 o_issue [rsv_pkg::ISSUE_PORTS]
);

    rsv_pkg::entry_wr_t wr [rsv_pkg::DSP_LANES];
    rsv_pkg::entry_t    entries [rsv_pkg::RSV_ENTRIES];
    rsv_pkg::rsv_vec_t  valid_vec;
    rsv_pkg::rsv_vec_t  release_vec;

    // Free entry offers and dispatch writes.
    rsv_alloc u_alloc (
        .i_dsp       (i_dsp),
        .i_valid_vec (valid_vec),
        .o_free      (o_free),
        .o_wr        (wr)
    );

    rsv_entry_table u_table (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wr        (wr),
        .i_release   (release_vec),
        .i_flush     (i_flush),
        .o_entries   (entries),
        .o_valid_vec (valid_vec)
    );

    // Oldest ready pick per port.
    rsv_issue_select u_select (
        .i_entries     (entries),
        .i_src1_rdy    (i_src1_rdy),
        .i_src2_rdy    (i_src2_rdy),
        .i_issue_stall (i_issue_stall),
        .o_issue       (o_issue),
        .o_release     (release_vec)
    );

endmodule

//--- rsv_ctrl_assertions.sv
`timescale 1ns/10ps

module rsv_ctrl_assertions (
    input logic                 clk,
    input logic                 i_rst,
    input rsv_pkg::flush_t      i_flush,
    input rsv_pkg::rsv_vec_t    i_valid_vec,
    input rsv_pkg::free_offer_t i_free [rsv_pkg::DSP_LANES],
    input rsv_pkg::issue_t      i_issue [rsv_pkg::ISSUE_PORTS]
);

    int assert_fails = 0;

    // Second offer sits above the first.
    offer_order: assert property (@(posedge clk) disable iff (i_rst)
        i_free[1].valid |-> (i_free[0].valid && (i_free[1].entry > i_free[0].entry)))
        else begin
            assert_fails++;
            $error("offer 1 is not above offer 0");
        end

    int_issue_valid: assert property (@(posedge clk) disable iff (i_rst)
        i_issue[0].valid |-> i_valid_vec[i_issue[0].entry])
        else begin
            assert_fails++;
            $error("integer port issues an invalid entry");
        end

    mem_issue_valid: assert property (@(posedge clk) disable iff (i_rst)
        i_issue[1].valid |-> i_valid_vec[i_issue[1].entry])
        else begin
            assert_fails++;
            $error("memory port issues an invalid entry");
        end

    // Queue is empty right after a trap.
    trap_empties: assert property (@(posedge clk) disable iff (i_rst)
        i_flush.trap |=> (i_valid_vec == '0))
        else begin
            assert_fails++;
            $error("entries still valid after a trap flush");
        end

endmodule

// Attached at the top, where table and select outputs meet.
bind rsv_ctrl rsv_ctrl_assertions u_assert (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_flush     (i_flush),
    .i_valid_vec (valid_vec),
    .i_free      (o_free),
    .i_issue     (o_issue)
);

//--- rsv_ctrl_tb.sv
`timescale 1ns/10ps

module rsv_ctrl_tb;

    // One golden line with the test number in field 0.
    typedef logic [22:0][15:0] row_t;

    logic                            clk = 1'b0;
    logic                            i_rst;
    rsv_pkg::dsp_req_t               dsp [rsv_pkg::DSP_LANES];
    rsv_pkg::flush_t                 flush;
    rsv_pkg::rsv_vec_t               src1_rdy;
    rsv_pkg::rsv_vec_t               src2_rdy;
    logic [rsv_pkg::ISSUE_PORTS-1:0] issue_stall;
    rsv_pkg::free_offer_t            free [rsv_pkg::DSP_LANES];
    rsv_pkg::issue_t                 issue [rsv_pkg::ISSUE_PORTS];

    row_t rows [$];
    bit   load_ok = 1'b1;
    int   test_errors = 0;
    int   cycle_count = 0;
    int   cycle_limit = 0;

    rsv_ctrl uut (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_dsp         (dsp),
        .i_flush       (flush),
        .i_src1_rdy    (src1_rdy),
        .i_src2_rdy    (src2_rdy),
        .i_issue_stall (issue_stall),
        .o_free        (free),
        .o_issue       (issue)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_golden();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        logic [15:0] v [23];
        row_t        r;
        fd = $fopen("rsv_ctrl_golden.txt", "r");
        if (fd == 0) begin
            $display("Golden file rsv_ctrl_golden.txt could not be opened");
            load_ok = 1'b0;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20],
                        v[21], v[22]);
            if (n != 23) begin
                $display("Golden line %0d is short, %0d of 23 fields", line_no, n);
                load_ok = 1'b0;
            end else begin
                for (int i = 0; i < 23; i++) begin
                    r[i] = v[i];
                end
                rows.push_back(r);
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            $display("Golden file holds no test lines");
            load_ok = 1'b0;
        end
    endtask

    task automatic drive_row(input row_t r);
        for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
            dsp[k].valid  = r[1 + 3 * k][0];
            dsp[k].rob_id = r[2 + 3 * k][7:0];
            dsp[k].unit   = rsv_pkg::exec_unit_e'(r[3 + 3 * k][2:0]);
        end
        flush.trap       = r[7][0];
        flush.mis        = r[8][0];
        flush.mis_rob_id = r[9][7:0];
        src1_rdy         = r[10];
        src2_rdy         = r[11];
        issue_stall      = r[12][1:0];
    endtask

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp, input int idx);
        assert (got === exp) else begin
            $display("** Error %s: got 0x%0h, expected 0x%0h (golden row %0d)",
                     name, got, exp, idx);
            test_errors++;
        end
    endtask

    // Entry and ROB id only count when the expected valid is set.
    task automatic check_row(input row_t r, input int idx);
        for (int k = 0; k < rsv_pkg::DSP_LANES; k++) begin
            check_field($sformatf("o_free[%0d].valid", k), free[k].valid, r[13 + 2 * k], idx);
            if (r[13 + 2 * k][0]) begin
                check_field($sformatf("o_free[%0d].entry", k), free[k].entry,
                            r[14 + 2 * k], idx);
            end
        end
        for (int p = 0; p < rsv_pkg::ISSUE_PORTS; p++) begin
            check_field($sformatf("o_issue[%0d].valid", p), issue[p].valid, r[17 + 3 * p], idx);
            if (r[17 + 3 * p][0]) begin
                check_field($sformatf("o_issue[%0d].entry", p), issue[p].entry,
                            r[18 + 3 * p], idx);
                check_field($sformatf("o_issue[%0d].rob_id", p), issue[p].rob_id,
                            r[19 + 3 * p], idx);
            end
        end
    endtask

    initial begin
        int passed;
        int failed;
        passed = 0;
        failed = 0;
        i_rst = 1'b1;
        drive_row('0);
        load_golden();
        cycle_limit = rows.size() + 10 + 20;
        repeat (10) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            drive_row(rows[i]);
            #4;
            check_row(rows[i], i);
            if (i == rows.size() - 1 || rows[i + 1][0] != rows[i][0]) begin
                if (test_errors == 0) begin
                    $display("Test %0d: passed", rows[i][0]);
                    passed++;
                end else begin
                    $display("Test %0d: %0d mismatches", rows[i][0], test_errors);
                    failed++;
                end
                test_errors = 0;
            end
            @(negedge clk);
        end
        $display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
                 passed, failed, uut.u_assert.assert_fails);
        if (load_ok && failed == 0 && uut.u_assert.assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- rsv_ctrl.f
rsv_pkg.sv
rsv_alloc.sv
rsv_entry_table.sv
rsv_issue_select.sv
rsv_ctrl.sv
rsv_ctrl_assertions.sv
rsv_ctrl_tb.sv

//--- Bender.yml
package:
  name: rsv_ctrl

sources:
  - rsv_pkg.sv
  - rsv_alloc.sv
  - rsv_entry_table.sv
  - rsv_issue_select.sv
  - rsv_ctrl.sv
  - target: test
    files:
      - rsv_ctrl_assertions.sv
      - rsv_ctrl_tb.sv

//--- rsv_ctrl_golden.txt
# test d0v d0rob d0unit d1v d1rob d1unit trap mis mis_rob src1 src2 stall, all hex but test
# expected: f0v f0e f1v f1e i0v i0e i0rob i1v i1e i1rob
1 0 00 0 0 00 0 0 0 00 ffff ffff 0 1 0 1 1 0 0 00 0 0 00
2 1 84 0 1 85 4 0 0 00 0000 0000 0 1 0 1 1 0 0 00 0 0 00
2 1 7e 1 1 7f 5 0 0 00 0000 0000 0 1 2 1 3 0 0 00 0 0 00
2 1 80 2 1 81 4 0 0 00 0000 0000 0 1 4 1 5 0 0 00 0 0 00
2 1 7c 3 1 7d 5 0 0 00 0000 0000 0 1 6 1 7 0 0 00 0 0 00
2 1 86 0 1 87 4 0 0 00 0000 0000 0 1 8 1 9 0 0 00 0 0 00
2 1 88 0 1 89 5 0 0 00 0000 0000 0 1 a 1 b 0 0 00 0 0 00
2 1 8a 1 1 8b 4 0 0 00 0000 0000 0 1 c 1 d 0 0 00 0 0 00
2 1 8c 2 1 8d 5 0 0 00 0000 0000 0 1 e 1 f 0 0 00 0 0 00
2 1 01 0 1 02 4 0 0 00 0000 0000 0 0 0 0 0 0 0 00 0 0 00
2 0 00 0 0 00 0 0 0 00 0000 0000 0 0 0 0 0 0 0 00 0 0 00
3 0 00 0 0 00 0 0 0 00 ffff 0000 3 0 0 0 0 0 0 00 0 0 00
3 0 00 0 0 00 0 0 0 00 ffff ffff 3 0 0 0 0 1 6 7c 1 7 7d
3 0 00 0 0 00 0 0 0 00 ffff ff3f 3 0 0 0 0 1 2 7e 1 3 7f
3 0 00 0 0 00 0 0 0 00 0005 ffff 3 0 0 0 0 1 2 7e 0 0 00
3 0 00 0 0 00 0 0 0 00 0033 0033 3 0 0 0 0 1 4 80 1 5 81
3 0 00 0 0 00 0 0 0 00 0102 ffff 3 0 0 0 0 1 8 86 1 1 85
4 0 00 0 0 00 0 0 0 00 ffff ffff 3 0 0 0 0 1 6 7c 1 7 7d
4 0 00 0 0 00 0 0 0 00 ffff ffff 3 0 0 0 0 1 6 7c 1 7 7d
4 0 00 0 0 00 0 0 0 00 ffff ffff 2 0 0 0 0 1 6 7c 1 7 7d
4 0 00 0 0 00 0 0 0 00 ffff ffff 2 1 6 0 0 1 2 7e 1 7 7d
4 0 00 0 0 00 0 0 0 00 ffff ffff 3 1 2 1 6 1 4 80 1 7 7d
4 0 00 0 0 00 0 0 0 00 ffff ffff 1 1 2 1 6 1 4 80 1 7 7d
4 1 90 0 1 91 4 0 0 00 ffff ffff 3 1 2 1 6 1 4 80 1 3 7f
4 0 00 0 0 00 0 0 0 00 ffff ffff 3 1 7 0 0 1 4 80 1 3 7f
5 1 a0 0 1 a1 4 0 1 88 ffff ffff 3 1 7 0 0 1 4 80 1 3 7f
5 0 00 0 0 00 0 0 0 00 ffff ffff 3 1 2 1 6 1 4 80 1 3 7f
5 0 00 0 0 00 0 0 0 00 0080 0080 3 1 2 1 6 0 0 00 0 0 00
5 0 00 0 0 00 0 0 0 00 fc44 fc44 3 1 2 1 6 1 a 88 0 0 00
6 1 b0 0 1 b1 4 1 0 00 0000 0000 0 1 2 1 6 0 0 00 0 0 00
6 0 00 0 0 00 0 0 0 00 ffff ffff 3 1 0 1 1 0 0 00 0 0 00
6 1 c0 5 1 c1 3 0 0 00 ffff ffff 0 1 0 1 1 0 0 00 0 0 00
6 0 00 0 0 00 0 0 0 00 ffff ffff 0 1 2 1 3 1 1 c1 1 0 c0
6 0 00 0 0 00 0 0 0 00 0000 0000 0 1 0 1 1 0 0 00 0 0 00
